//--- Makefile
# Verilator build for the CNN layer testbench.

VERILATOR  ?= verilator
TOP        ?= tb_cnn_top
DUT_TOP    ?= cnn_top
FILELIST   ?= cnn_top.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= all tests passed
VFLAGS     ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing -f $(FILELIST) --top-module $(DUT_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass line appears in the output.
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- cnn_ctrl_pkg.sv
package cnn_ctrl_pkg;

    // convolution engine sequence, one pass per output pixel.
    typedef enum logic [2:0] {
        conv_idle,
        conv_fetch,        // reads issued, one tap per cycle.
        conv_accumulate,   // last product arrives.
        conv_finish,       // bias, relu and saturation.
        conv_store
    } conv_state_t;

    // pooling sequence, one pass per 2x2 block.
    typedef enum logic [1:0] {
        pool_idle,
        pool_read,
        pool_emit
    } pool_state_t;

endpackage

//--- cnn_data_pkg.sv
package cnn_data_pkg;

    // **********************************************************************
    // numeric types
    // **********************************************************************

    typedef logic signed [7:0]  pixel_t;   // image and feature map value.
    typedef logic signed [7:0]  weight_t;  // kernel tap or bias.
    typedef logic signed [19:0] acc_t;     // nine 8x8 products plus bias.

    // **********************************************************************
    // arithmetic constants
    // **********************************************************************

    localparam int     kernel_size = 3;          // square kernel side.
    localparam int     out_shift   = 4;          // scaling before saturation.
    localparam pixel_t pix_max     = 8'sd127;    // saturation ceiling.

endpackage

//--- cnn_top.f
cnn_data_pkg.sv
cnn_ctrl_pkg.sv
image_mem.sv
conv_layer.sv
feature_mem.sv
pool_unit.sv
cnn_top.sv
tb_clock_gen.sv
tb_cnn_top.sv

//--- cnn_top.sv
`timescale 1ns/100ps

module cnn_top import cnn_data_pkg::*; #(
    parameter int  h      = 10,
    parameter int  w      = 10,
    localparam int img_aw = $clog2(h * w),
    localparam int fm_aw  = $clog2((h - 2) * (w - 2))
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              pix_wr,
    input  logic [img_aw-1:0] pix_addr,
    input  pixel_t            pix_data,
    input  logic              w_wr,
    input  logic [3:0]        w_idx,
    input  weight_t           w_data,
    input  logic              start,
    output pixel_t            y,
    output logic              y_valid,
    output logic              done
);

    logic [img_aw-1:0] rd_addr;
    pixel_t            rd_data;
    logic              store;
    logic [fm_aw-1:0]  st_addr;
    pixel_t            st_data;
    logic              cout_done;
    logic [fm_aw-1:0]  fm_addr;
    pixel_t            fm_data;

    image_mem #(.h(h), .w(w)) mem_inst (
        .clk      (clk),
        .reset    (reset),
        .pix_wr   (pix_wr),
        .pix_addr (pix_addr),
        .pix_data (pix_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    conv_layer #(.h(h), .w(w)) layer_inst (
        .clk       (clk),
        .reset     (reset),
        .w_wr      (w_wr),
        .w_idx     (w_idx),
        .w_data    (w_data),
        .start     (start),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .store     (store),
        .st_addr   (st_addr),
        .st_data   (st_data),
        .cout_done (cout_done)
    );

    feature_mem #(.h(h), .w(w)) layer_mem_inst (
        .clk     (clk),
        .reset   (reset),
        .store   (store),
        .st_addr (st_addr),
        .st_data (st_data),
        .fm_addr (fm_addr),
        .fm_data (fm_data)
    );

    // pooling starts when the conv map is complete.
    pool_unit #(.h(h), .w(w)) pool_inst (
        .clk       (clk),
        .reset     (reset),
        .cout_done (cout_done),
        .fm_addr   (fm_addr),
        .fm_data   (fm_data),
        .y         (y),
        .y_valid   (y_valid),
        .pool_done (done)
    );

endmodule

//--- conv_layer.sv
`timescale 1ns/100ps

module conv_layer import cnn_data_pkg::*, cnn_ctrl_pkg::*; #(
    parameter int  h      = 10,
    parameter int  w      = 10,
    localparam int img_aw = $clog2(h * w),
    localparam int fm_aw  = $clog2((h - 2) * (w - 2))
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              w_wr,
    input  logic [3:0]        w_idx,
    input  weight_t           w_data,
    input  logic              start,
    output logic [img_aw-1:0] rd_addr,
    input  pixel_t            rd_data,
    output logic              store,
    output logic [fm_aw-1:0]  st_addr,
    output pixel_t            st_data,
    output logic              cout_done
);

    localparam int ch    = h - 2;                      // conv map height.
    localparam int cw    = w - 2;                      // conv map width.
    localparam int taps  = kernel_size * kernel_size;
    localparam int row_w = $clog2(ch + 1);
    localparam int col_w = $clog2(cw + 1);

    conv_state_t        state;
    weight_t            kernel [0:taps-1];
    weight_t            bias;
    logic [row_w-1:0]   out_row;
    logic [col_w-1:0]   out_col;
    logic [fm_aw-1:0]   out_idx;
    logic [1:0]         kx;
    logic [1:0]         ky;
    logic [3:0]         tap;
    logic [3:0]         tap_d;          // tap of the data now on rd_data.
    logic               fetch_valid;
    logic signed [15:0] product;
    acc_t               acc;
    logic               last_out;

    function automatic pixel_t relu_sat(acc_t sum);
        acc_t shifted;
        shifted = sum >>> out_shift;
        if (sum < 0) begin
            return '0;
        end else if (shifted > acc_t'(pix_max)) begin
            return pix_max;
        end
        return pixel_t'(shifted);
    endfunction

    // **********************************************************************
    // kernel and bias registers
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (w_wr) begin
            if (w_idx < taps) begin
                kernel[w_idx] <= w_data;
            end else if (w_idx == taps) begin
                bias <= w_data;  // index 9.
            end
        end
    end

    // **********************************************************************
    // window sequencer and accumulator
    // **********************************************************************

    assign rd_addr  = img_aw'((out_row + ky) * w + out_col + kx);
    assign product  = rd_data * kernel[tap_d];
    assign last_out = (out_row == ch - 1) && (out_col == cw - 1);
    assign st_addr  = out_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= conv_idle;
            store       <= 1'b0;
            cout_done   <= 1'b0;
            fetch_valid <= 1'b0;
            tap_d       <= '0;
            acc         <= '0;
            out_row     <= '0;
            out_col     <= '0;
            out_idx     <= '0;
            kx          <= '0;
            ky          <= '0;
            tap         <= '0;
        end else begin
            store       <= 1'b0;
            cout_done   <= 1'b0;
            fetch_valid <= (state == conv_fetch);
            tap_d       <= tap;
            if (fetch_valid) begin
                acc <= acc + product;  // overlaps the next fetch.
            end
            case (state)
                conv_idle: begin
                    if (start) begin
                        out_row <= '0;
                        out_col <= '0;
                        out_idx <= '0;
                        acc     <= '0;
                        state   <= conv_fetch;
                    end
                end
                conv_fetch: begin
                    tap <= tap + 1'b1;
                    if (kx == kernel_size - 1) begin
                        kx <= '0;
                        ky <= ky + 1'b1;
                    end else begin
                        kx <= kx + 1'b1;
                    end
                    if (tap == taps - 1) begin
                        tap   <= '0;
                        kx    <= '0;
                        ky    <= '0;
                        state <= conv_accumulate;
                    end
                end
                conv_accumulate: state <= conv_finish;  // ninth product lands.
                conv_finish: begin
                    store <= 1'b1;
                    state <= conv_store;
                end
                conv_store: begin
                    acc     <= '0;
                    out_idx <= out_idx + 1'b1;
                    if (last_out) begin
                        cout_done <= 1'b1;
                        state     <= conv_idle;
                    end else begin
                        if (out_col == cw - 1) begin
                            out_col <= '0;
                            out_row <= out_row + 1'b1;
                        end else begin
                            out_col <= out_col + 1'b1;
                        end
                        state <= conv_fetch;
                    end
                end
                default: state <= conv_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == conv_finish) begin
            st_data <= relu_sat(acc + acc_t'(bias));
        end
    end

    a_store_in_state: assert property (@(posedge clk) disable iff (reset)
        store |-> state == conv_store);

    a_done_after_last: assert property (@(posedge clk) disable iff (reset)
        cout_done |-> $past(store && st_addr == fm_aw'(ch * cw - 1)));

endmodule

//--- feature_mem.sv
`timescale 1ns/100ps

module feature_mem import cnn_data_pkg::*; #(
    parameter int  h     = 10,
    parameter int  w     = 10,
    localparam int fm_aw = $clog2((h - 2) * (w - 2))
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             store,
    input  logic [fm_aw-1:0] st_addr,
    input  pixel_t           st_data,
    input  logic [fm_aw-1:0] fm_addr,
    output pixel_t           fm_data
);

    localparam int depth = (h - 2) * (w - 2);  // one conv output map.

    pixel_t buffer [0:depth-1];

    always_ff @(posedge clk) begin
        if (store) begin
            buffer[st_addr] <= st_data;
        end
    end

    // registered read for the pooling unit.
    always_ff @(posedge clk) begin
        if (reset) begin
            fm_data <= '0;
        end else begin
            fm_data <= buffer[fm_addr];
        end
    end

    a_st_addr_range: assert property (@(posedge clk) disable iff (reset)
        store |-> st_addr < depth);

endmodule

//--- image_mem.sv
`timescale 1ns/100ps

module image_mem import cnn_data_pkg::*; #(
    parameter int  h      = 10,
    parameter int  w      = 10,
    localparam int img_aw = $clog2(h * w)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              pix_wr,
    input  logic [img_aw-1:0] pix_addr,
    input  pixel_t            pix_data,
    input  logic [img_aw-1:0] rd_addr,
    output pixel_t            rd_data
);

    localparam int depth = h * w;

    pixel_t mem [0:depth-1];

    // write port, loaded from outside before start.
    always_ff @(posedge clk) begin
        if (pix_wr) begin
            mem[pix_addr] <= pix_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_addr];  // one cycle of read latency.
        end
    end

    a_pix_addr_range: assert property (@(posedge clk) disable iff (reset)
        pix_wr |-> pix_addr < depth);

endmodule

//--- pool_unit.sv
`timescale 1ns/100ps

module pool_unit import cnn_data_pkg::*, cnn_ctrl_pkg::*; #(
    parameter int  h     = 10,
    parameter int  w     = 10,
    localparam int fm_aw = $clog2((h - 2) * (w - 2))
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             cout_done,
    output logic [fm_aw-1:0] fm_addr,
    input  pixel_t           fm_data,
    output pixel_t           y,
    output logic             y_valid,
    output logic             pool_done
);

    localparam int cw   = w - 2;
    localparam int bh   = (h - 2) / 2;   // pooled rows.
    localparam int bw   = (w - 2) / 2;   // pooled columns.
    localparam int br_w = $clog2(bh + 1);
    localparam int bc_w = $clog2(bw + 1);

    pool_state_t     state;
    logic [br_w-1:0] blk_row;
    logic [bc_w-1:0] blk_col;
    logic [1:0]      sub;        // position inside the block, dy then dx.
    logic            rd_valid;
    logic            rd_first;
    logic            done_pend;
    logic            last_blk;
    pixel_t          run_max;
    pixel_t          blk_max;

    assign fm_addr  = fm_aw'((2 * blk_row + sub[1]) * cw + 2 * blk_col + sub[0]);
    assign blk_max  = (rd_first || fm_data > run_max) ? fm_data : run_max;
    assign last_blk = (blk_row == bh - 1) && (blk_col == bw - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= pool_idle;
            y_valid   <= 1'b0;
            pool_done <= 1'b0;
            done_pend <= 1'b0;
            rd_valid  <= 1'b0;
            rd_first  <= 1'b0;
            blk_row   <= '0;
            blk_col   <= '0;
            sub       <= '0;
        end else begin
            y_valid   <= 1'b0;
            done_pend <= 1'b0;
            pool_done <= done_pend;  // one cycle behind the last y_valid.
            rd_valid  <= (state == pool_read);
            rd_first  <= (state == pool_read) && (sub == 2'd0);
            case (state)
                pool_idle: begin
                    if (cout_done) begin
                        blk_row <= '0;
                        blk_col <= '0;
                        sub     <= '0;
                        state   <= pool_read;
                    end
                end
                pool_read: begin
                    sub <= sub + 1'b1;
                    if (sub == 2'd3) begin
                        state <= pool_emit;
                    end
                end
                pool_emit: begin
                    y_valid <= 1'b1;
                    if (last_blk) begin
                        done_pend <= 1'b1;
                        state     <= pool_idle;
                    end else begin
                        if (blk_col == bw - 1) begin
                            blk_col <= '0;
                            blk_row <= blk_row + 1'b1;
                        end else begin
                            blk_col <= blk_col + 1'b1;
                        end
                        state <= pool_read;
                    end
                end
                default: state <= pool_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            run_max <= blk_max;
        end
        if (state == pool_emit) begin
            y <= blk_max;  // fourth value arrives in this cycle.
        end
    end

    a_valid_done_apart: assert property (@(posedge clk) disable iff (reset)
        !(y_valid && pool_done));

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period       = 4,  // ns.
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;  // released on a falling edge.
    end

endmodule

//--- tb_cnn_top.sv
`timescale 1ns/100ps

module tb_cnn_top import cnn_data_pkg::*; ();

    localparam int h      = 10;
    localparam int w      = 10;
    localparam int img_aw = $clog2(h * w);
    localparam int ch     = h - 2;
    localparam int cw     = w - 2;
    localparam int n_pool = (ch / 2) * (cw / 2);

    logic              clk;
    logic              reset;
    logic              pix_wr;
    logic [img_aw-1:0] pix_addr;
    pixel_t            pix_data;
    logic              w_wr;
    logic [3:0]        w_idx;
    weight_t           w_data;
    logic              start;
    pixel_t            y;
    logic              y_valid;
    logic              done;

    pixel_t      img_pix [0:h*w-1];
    weight_t     ker_w [0:8];
    weight_t     bias_w;
    pixel_t      exp_pool [0:n_pool-1];
    pixel_t      expected_y;
    logic [15:0] lfsr_state;
    int          y_count;
    logic        run_active;
    int          const_expect;   // -1 when no fixed output is expected.
    int          error_count;
    int          errs_before;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;      // later runs are skipped once set.

    tb_clock_gen #(.period(4), .reset_cycles(8)) i_clock (.clk(clk), .reset(reset));

    cnn_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .pix_wr   (pix_wr),
        .pix_addr (pix_addr),
        .pix_data (pix_data),
        .w_wr     (w_wr),
        .w_idx    (w_idx),
        .w_data   (w_data),
        .start    (start),
        .y        (y),
        .y_valid  (y_valid),
        .done     (done)
    );

    // **********************************************************************
    // scoreboard
    // **********************************************************************

    assign expected_y = (y_count < n_pool) ? exp_pool[y_count] : '0;

    always @(posedge clk) begin
        if (reset) begin
            run_active <= 1'b0;
            y_count    <= 0;
        end else begin
            if (start && !run_active) begin
                run_active <= 1'b1;  // a start inside a run is not a new run.
                y_count    <= 0;
            end else if (done) begin
                run_active <= 1'b0;
            end
            if (y_valid) begin
                y_count <= y_count + 1;
            end
        end
    end

    task automatic flag_error(input string msg);
        error_count++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    a_quiet_when_idle: assert property (@(posedge clk) disable iff (reset)
        !run_active |-> !y_valid && !done)
        else flag_error("y_valid or done high outside a run");

    a_y_matches_model: assert property (@(posedge clk) disable iff (reset)
        y_valid |-> y == expected_y)
        else flag_error($sformatf("pooled value %0d is %0d, expected %0d",
            $sampled(y_count), $sampled(y), $sampled(expected_y)));

    a_y_fixed_value: assert property (@(posedge clk) disable iff (reset)
        (y_valid && const_expect >= 0) |-> int'(y) == const_expect)
        else flag_error($sformatf("y is %0d, expected %0d", $sampled(y), const_expect));

    a_count_in_range: assert property (@(posedge clk) disable iff (reset)
        y_valid |-> y_count < n_pool)
        else flag_error("more y_valid strobes than pooled outputs");

    a_count_at_done: assert property (@(posedge clk) disable iff (reset)
        done |-> y_count == n_pool)
        else flag_error($sformatf("done after %0d strobes, expected %0d",
            $sampled(y_count), n_pool));

    // **********************************************************************
    // stimulus and reference model
    // **********************************************************************

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] next_random(input int nbits);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic fill_image(input int base, input int nbits);
        for (int a = 0; a < h * w; a++) begin
            img_pix[a] = pixel_t'(base + int'(next_random(nbits)));
        end
    endtask

    task automatic random_weights();
        logic [7:0] b;
        for (int t = 0; t < 9; t++) begin
            b = next_random(4);
            ker_w[t] = {{4{b[3]}}, b[3:0]};  // small signed taps.
        end
        bias_w = next_random(8);
    endtask

    task automatic build_expected();
        int conv [0:ch*cw-1];
        int sum;
        int best;
        for (int r = 0; r < ch; r++) begin
            for (int c = 0; c < cw; c++) begin
                sum = int'(bias_w);
                for (int t = 0; t < 9; t++) begin
                    sum += int'(img_pix[(r + t / 3) * w + c + t % 3]) * int'(ker_w[t]);
                end
                if (sum < 0) begin
                    conv[r * cw + c] = 0;
                end else begin
                    conv[r * cw + c] = ((sum >> out_shift) > 127) ? 127 : (sum >> out_shift);
                end
            end
        end
        for (int br = 0; br < ch / 2; br++) begin
            for (int bc = 0; bc < cw / 2; bc++) begin
                best = conv[2 * br * cw + 2 * bc];
                for (int k = 1; k < 4; k++) begin
                    if (conv[(2 * br + k / 2) * cw + 2 * bc + k % 2] > best) begin
                        best = conv[(2 * br + k / 2) * cw + 2 * bc + k % 2];
                    end
                end
                exp_pool[br * (cw / 2) + bc] = pixel_t'(best);
            end
        end
    endtask

    task automatic load_layer(input bit with_image);
        if (with_image) begin
            for (int a = 0; a < h * w; a++) begin
                @(negedge clk);
                pix_wr   = 1'b1;
                pix_addr = img_aw'(a);
                pix_data = img_pix[a];
            end
            @(negedge clk);
            pix_wr = 1'b0;
        end
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            w_wr   = 1'b1;
            w_idx  = 4'(i);
            w_data = (i < 9) ? ker_w[i] : bias_w;  // index 9 is the bias.
        end
        @(negedge clk);
        w_wr = 1'b0;
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && cycles < limit);
        if (!done) begin
            error_count++;
            timed_out = 1'b1;
            $display("timeout: done did not arrive within %0d cycles", limit);
        end
    endtask

    task automatic run_layer(input int restart_after);
        if (!timed_out) begin
            build_expected();
            @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            if (restart_after > 0) begin
                repeat (restart_after) @(negedge clk);
                start = 1'b1;  // lands while the engine is busy.
                @(negedge clk);
                start = 1'b0;
            end
            wait_for_done(2000);
            repeat (12) @(negedge clk);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (error_count == errs_before && !timed_out) begin
            $display("test %0d, %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d, %s: FAILED", tests_run, name);
        end
        errs_before = error_count;
    endtask

    initial begin
        int cycles;
        pix_wr       = 1'b0;
        pix_addr     = '0;
        pix_data     = '0;
        w_wr         = 1'b0;
        w_idx        = '0;
        w_data       = '0;
        start        = 1'b0;
        lfsr_state   = 16'd57460;
        const_expect = -1;
        error_count  = 0;
        errs_before  = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        cycles       = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (reset && cycles < 50);
        if (reset) begin
            error_count++;
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end
        repeat (20) @(negedge clk);
        report_test("idle after reset");

        fill_image(0, 8);
        random_weights();
        load_layer(1'b1);
        run_layer(0);
        report_test("random image and weights");

        fill_image(64, 6);  // bright positive pixels.
        for (int t = 0; t < 9; t++) begin
            ker_w[t] = 8'sd127;
        end
        bias_w       = next_random(8);
        const_expect = 127;
        load_layer(1'b1);
        run_layer(0);
        report_test("saturation");

        for (int t = 0; t < 9; t++) begin
            ker_w[t] = weight_t'(-1 - int'(next_random(7)));
        end
        bias_w       = '0;
        const_expect = 0;
        load_layer(1'b0);
        run_layer(0);
        report_test("relu");

        const_expect = -1;
        fill_image(0, 8);
        random_weights();
        load_layer(1'b1);
        run_layer(40);
        random_weights();
        load_layer(1'b0);
        run_layer(0);
        report_test("start during a run");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
